// File: design/isaPkg.sv
package isaPkg;

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP     = 7'b0110011,    // Register-register ALU
        OP_IMM = 7'b0010011,    // Register-immediate ALU
        LOAD   = 7'b0000011,    // LW only
        STORE  = 7'b0100011,    // SW only
        BRANCH = 7'b1100011,    // Conditional branches
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_t;

    // ALU funct3, shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;   // Arith/logic split by bit 30
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    // Value of instruction bit 30 (funct7[5]) that selects SUB or SRA/SRAI
    // instead of ADD or SRL/SRLI
    localparam logic funct7Alt = 1'b1;

endpackage

// File: design/coreCtrlPkg.sv
package coreCtrlPkg;

    // ALU operation, driven by the controller
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,      // Signed compare, 0 or 1
        ALU_SLTU,     // Unsigned compare, 0 or 1
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB     // Operand B straight through, used by LUI
    } aluOp_t;

    // Next PC source
    typedef enum logic [1:0] {
        PC_PLUS4,     // Sequential
        PC_BRANCH,    // PC + immediate, taken branch and JAL
        PC_JALR       // rs1 + immediate with bit 0 cleared
    } pcSel_t;

    // Register write-back source
    typedef enum logic [1:0] {
        WB_ALU,       // ALU result
        WB_MEM,       // Load data
        WB_PC4        // Link address
    } wbSel_t;

endpackage

// File: design/instructionDecoder.sv
module instructionDecoder
    import isaPkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int REG_WIDTH  = 5
) (
    input  logic [31:0]           i_Inst,   // Instruction word
    output logic [REG_WIDTH-1:0]  o_Rs1,    // Source register 1
    output logic [REG_WIDTH-1:0]  o_Rs2,    // Source register 2
    output logic [REG_WIDTH-1:0]  o_Rd,     // Destination register
    output logic [DATA_WIDTH-1:0] o_Imm     // Sign-extended immediate
);

    opcode_t            opcode;
    logic signed [31:0] imm;    // Immediate before resizing to the datapath

    assign opcode = opcode_t'(i_Inst[6:0]);

    // Register fields sit at the same place in every format
    assign o_Rs1 = i_Inst[15 +: REG_WIDTH];
    assign o_Rs2 = i_Inst[20 +: REG_WIDTH];
    assign o_Rd  = i_Inst[7 +: REG_WIDTH];

    // Immediate format follows the opcode, sign always from bit 31
    always_comb begin
        case (opcode)
            OP_IMM, LOAD, JALR: begin   // I type
                imm = {{20{i_Inst[31]}}, i_Inst[31:20]};
            end
            STORE: begin                // S type
                imm = {{20{i_Inst[31]}}, i_Inst[31:25], i_Inst[11:7]};
            end
            BRANCH: begin               // B type, halfword offset
                imm = {{19{i_Inst[31]}}, i_Inst[31], i_Inst[7],
                       i_Inst[30:25], i_Inst[11:8], 1'b0};
            end
            LUI, AUIPC: begin           // U type, upper 20 bits
                imm = {i_Inst[31:12], 12'b0};
            end
            JAL: begin                  // J type, halfword offset
                imm = {{11{i_Inst[31]}}, i_Inst[31], i_Inst[19:12],
                       i_Inst[20], i_Inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;               // R type and unknown opcodes carry none
            end
        endcase
    end

    // Signed cast keeps the sign on a wider datapath
    assign o_Imm = DATA_WIDTH'(imm);

endmodule

// File: design/datapathController.sv
module datapathController
    import isaPkg::*;
    import coreCtrlPkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  i_rstN,          // Holds write strobes low
    input  logic [31:0]           i_Inst,          // Instruction word
    input  logic [DATA_WIDTH-1:0] i_RdDataA,       // rs1 value, branch compare
    input  logic [DATA_WIDTH-1:0] i_RdDataB,       // rs2 value, branch compare
    output aluOp_t                o_AluOp,         // ALU operation
    output logic                  o_OperandASel,   // 0 rs1, 1 PC
    output logic                  o_OperandBSel,   // 0 rs2, 1 immediate
    output pcSel_t                o_PcSel,         // Next PC source
    output wbSel_t                o_WbSel,         // Write-back source
    output logic                  o_RegWrEnable,   // Register file write
    output logic                  o_MemWrEnable    // Data memory write
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       altBit;        // Instruction bit 30
    logic       isEq;
    logic       isLt;          // Signed less than
    logic       isLtu;         // Unsigned less than
    logic       branchTaken;
    logic       regWr;         // Write strobes before reset gating
    logic       memWr;

    assign opcode = opcode_t'(i_Inst[6:0]);
    assign funct3 = i_Inst[14:12];
    assign altBit = i_Inst[30];

    // Map funct3 to an ALU op
    // Bit 30 only means SUB for OP, since ADDI uses it as immediate
    function automatic aluOp_t decodeAluOp(input logic [2:0] f3, input logic alt,
                                           input logic isReg);
        aluOp_t op;
        case (f3)
            F3_ADD_SUB: op = (isReg && alt == funct7Alt) ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = (alt == funct7Alt) ? ALU_SRA : ALU_SRL; // SRAI too
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_ADD;
        endcase
        return op;
    endfunction

    // Register comparisons for branches
    assign isEq  = i_RdDataA == i_RdDataB;
    assign isLt  = $signed(i_RdDataA) < $signed(i_RdDataB);
    assign isLtu = i_RdDataA < i_RdDataB;

    always_comb begin
        case (funct3)
            F3_BEQ:  branchTaken = isEq;
            F3_BNE:  branchTaken = !isEq;
            F3_BLT:  branchTaken = isLt;
            F3_BGE:  branchTaken = !isLt;
            F3_BLTU: branchTaken = isLtu;
            F3_BGEU: branchTaken = !isLtu;
            default: branchTaken = 1'b0;    // Reserved encodings fall through
        endcase
    end

    always_comb begin
        // Defaults give a no-op, PC + 4 and no writes
        o_AluOp       = ALU_ADD;
        o_OperandASel = 1'b0;
        o_OperandBSel = 1'b0;
        o_PcSel       = PC_PLUS4;
        o_WbSel       = WB_ALU;
        regWr         = 1'b0;
        memWr         = 1'b0;
        case (opcode)
            OP: begin
                o_AluOp = decodeAluOp(funct3, altBit, 1'b1);
                regWr   = 1'b1;
            end
            OP_IMM: begin
                o_AluOp       = decodeAluOp(funct3, altBit, 1'b0);
                o_OperandBSel = 1'b1;
                regWr         = 1'b1;
            end
            LOAD: begin                     // Address is rs1 + imm
                o_OperandBSel = 1'b1;
                o_WbSel       = WB_MEM;
                regWr         = 1'b1;
            end
            STORE: begin
                o_OperandBSel = 1'b1;
                memWr         = 1'b1;
            end
            BRANCH: begin
                if (branchTaken) begin
                    o_PcSel = PC_BRANCH;
                end
            end
            JAL: begin
                o_PcSel = PC_BRANCH;        // Same PC + imm adder
                o_WbSel = WB_PC4;
                regWr   = 1'b1;
            end
            JALR: begin
                o_PcSel = PC_JALR;
                o_WbSel = WB_PC4;
                regWr   = 1'b1;
            end
            LUI: begin
                o_AluOp       = ALU_PASSB;
                o_OperandBSel = 1'b1;
                regWr         = 1'b1;
            end
            AUIPC: begin                    // PC + upper immediate
                o_OperandASel = 1'b1;
                o_OperandBSel = 1'b1;
                regWr         = 1'b1;
            end
            default: ;
        endcase
    end

    // No state may change while in reset
    assign o_RegWrEnable = regWr & i_rstN;
    assign o_MemWrEnable = memWr & i_rstN;

endmodule

// File: design/registerFile.sv
module registerFile #(
    parameter int DATA_WIDTH = 32,
    parameter int REG_WIDTH  = 5
) (
    input  logic                  i_Clock,
    input  logic                  i_rstN,       // Clears all registers
    input  logic                  i_WrEnable,   // Write strobe
    input  logic [REG_WIDTH-1:0]  i_WrAddr,     // Write index
    input  logic [DATA_WIDTH-1:0] i_WrData,     // Write value
    input  logic [REG_WIDTH-1:0]  i_RdAddrA,    // Read index A
    input  logic [REG_WIDTH-1:0]  i_RdAddrB,    // Read index B
    output logic [DATA_WIDTH-1:0] o_RdDataA,    // Read value A
    output logic [DATA_WIDTH-1:0] o_RdDataB     // Read value B
);

    localparam int NUM_REGS = 2 ** REG_WIDTH;

    logic [DATA_WIDTH-1:0] regs [NUM_REGS];

    // Entry 0 is cleared by reset and never written, so it reads zero
    always_ff @(posedge i_Clock) begin
        if (!i_rstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_WrEnable && i_WrAddr != '0) begin
            regs[i_WrAddr] <= i_WrData;
        end
    end

    // Combinational reads
    // A write in the same cycle shows up only after the edge
    assign o_RdDataA = regs[i_RdAddrA];
    assign o_RdDataB = regs[i_RdAddrB];

endmodule

// File: design/alu.sv
module alu
    import coreCtrlPkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  aluOp_t                i_Op,         // Operation
    input  logic [DATA_WIDTH-1:0] i_OperandA,   // rs1 or PC
    input  logic [DATA_WIDTH-1:0] i_OperandB,   // rs2 or immediate
    output logic [DATA_WIDTH-1:0] o_Result
);

    localparam int SHAMT_WIDTH = $clog2(DATA_WIDTH);    // 5 for RV32

    logic [SHAMT_WIDTH-1:0] shamt;
    logic                   lessSigned;
    logic                   lessUnsigned;

    // Upper bits of the shift amount are ignored
    assign shamt = i_OperandB[SHAMT_WIDTH-1:0];

    assign lessSigned   = $signed(i_OperandA) < $signed(i_OperandB);
    assign lessUnsigned = i_OperandA < i_OperandB;

    always_comb begin
        case (i_Op)
            ALU_ADD:   o_Result = i_OperandA + i_OperandB;
            ALU_SUB:   o_Result = i_OperandA - i_OperandB;
            ALU_SLL:   o_Result = i_OperandA << shamt;
            ALU_SLT:   o_Result = DATA_WIDTH'(lessSigned);     // Zero-extended flag
            ALU_SLTU:  o_Result = DATA_WIDTH'(lessUnsigned);
            ALU_XOR:   o_Result = i_OperandA ^ i_OperandB;
            ALU_SRL:   o_Result = i_OperandA >> shamt;
            ALU_SRA:   o_Result = $unsigned($signed(i_OperandA) >>> shamt); // Sign fill
            ALU_OR:    o_Result = i_OperandA | i_OperandB;
            ALU_AND:   o_Result = i_OperandA & i_OperandB;
            ALU_PASSB: o_Result = i_OperandB;
            default:   o_Result = '0;
        endcase
    end

endmodule

// File: design/processorSc.sv
module processorSc
    import coreCtrlPkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int PC_WIDTH   = 32,
    parameter int REG_WIDTH  = 5
) (
    input  logic                  i_Clock,
    input  logic                  i_rstN,          // Synchronous, active low

    output logic [PC_WIDTH-1:0]   o_PgmAddr,       // Instruction address
    input  logic [31:0]           i_PgmInst,       // Instruction, same cycle

    output logic [DATA_WIDTH-1:0] o_MemAddr,       // Data address
    output logic                  o_MemWrEnable,   // Store strobe
    output logic [DATA_WIDTH-1:0] o_MemWrData,     // Store data
    input  logic [DATA_WIDTH-1:0] i_MemRdData      // Load data, same cycle
);

    logic [PC_WIDTH-1:0]   pc;
    logic [PC_WIDTH-1:0]   pcNext;
    logic [PC_WIDTH-1:0]   pcPlus4;
    logic [PC_WIDTH-1:0]   pcPlusImm;      // Branch and JAL target
    logic [PC_WIDTH-1:0]   rs1PlusImm;     // JALR target before LSB clear

    logic [REG_WIDTH-1:0]  rs1;
    logic [REG_WIDTH-1:0]  rs2;
    logic [REG_WIDTH-1:0]  rd;
    logic [DATA_WIDTH-1:0] imm;

    aluOp_t                aluOp;
    logic                  operandASel;
    logic                  operandBSel;
    pcSel_t                pcSel;
    wbSel_t                wbSel;
    logic                  regWrEnable;

    logic [DATA_WIDTH-1:0] rdDataA;
    logic [DATA_WIDTH-1:0] rdDataB;
    logic [DATA_WIDTH-1:0] operandA;
    logic [DATA_WIDTH-1:0] operandB;
    logic [DATA_WIDTH-1:0] aluResult;
    logic [DATA_WIDTH-1:0] wbData;

    instructionDecoder #(
        .DATA_WIDTH (DATA_WIDTH),
        .REG_WIDTH  (REG_WIDTH)
    ) decoder_i (
        .i_Inst (i_PgmInst),
        .o_Rs1  (rs1),
        .o_Rs2  (rs2),
        .o_Rd   (rd),
        .o_Imm  (imm)
    );

    datapathController #(
        .DATA_WIDTH (DATA_WIDTH)
    ) ctrl_i (
        .i_rstN        (i_rstN),
        .i_Inst        (i_PgmInst),
        .i_RdDataA     (rdDataA),
        .i_RdDataB     (rdDataB),
        .o_AluOp       (aluOp),
        .o_OperandASel (operandASel),
        .o_OperandBSel (operandBSel),
        .o_PcSel       (pcSel),
        .o_WbSel       (wbSel),
        .o_RegWrEnable (regWrEnable),
        .o_MemWrEnable (o_MemWrEnable)
    );

    registerFile #(
        .DATA_WIDTH (DATA_WIDTH),
        .REG_WIDTH  (REG_WIDTH)
    ) regFile_i (
        .i_Clock    (i_Clock),
        .i_rstN     (i_rstN),
        .i_WrEnable (regWrEnable),
        .i_WrAddr   (rd),
        .i_WrData   (wbData),
        .i_RdAddrA  (rs1),
        .i_RdAddrB  (rs2),
        .o_RdDataA  (rdDataA),
        .o_RdDataB  (rdDataB)
    );

    // Operand A is PC only for AUIPC
    assign operandA = operandASel ? DATA_WIDTH'(pc) : rdDataA;
    assign operandB = operandBSel ? imm : rdDataB;

    alu #(
        .DATA_WIDTH (DATA_WIDTH)
    ) alu_i (
        .i_Op       (aluOp),
        .i_OperandA (operandA),
        .i_OperandB (operandB),
        .o_Result   (aluResult)
    );

    // Write-back select
    always_comb begin
        case (wbSel)
            WB_MEM:  wbData = i_MemRdData;
            WB_PC4:  wbData = DATA_WIDTH'(pcPlus4);   // Link address
            default: wbData = aluResult;
        endcase
    end

    // PC adders
    assign pcPlus4    = pc + PC_WIDTH'(4);
    assign pcPlusImm  = pc + PC_WIDTH'(imm);
    assign rs1PlusImm = PC_WIDTH'(rdDataA) + PC_WIDTH'(imm);

    always_comb begin
        case (pcSel)
            PC_BRANCH: pcNext = pcPlusImm;
            PC_JALR:   pcNext = {rs1PlusImm[PC_WIDTH-1:1], 1'b0};
            default:   pcNext = pcPlus4;
        endcase
    end

    // Program counter, starts at 0
    always_ff @(posedge i_Clock) begin
        if (!i_rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    assign o_PgmAddr   = pc;
    assign o_MemAddr   = aluResult;    // rs1 + imm for LW and SW
    assign o_MemWrData = rdDataB;

endmodule

// File: bench/testTable.svh
`ifndef TEST_TABLE_SVH
`define TEST_TABLE_SVH

localparam int NUM_TESTS  = 8;
localparam int MAX_PROG   = 20;
localparam int MAX_STORES = 8;

// RV32I major opcodes
localparam int OPC_IMM   = 'h13;
localparam int OPC_LOAD  = 'h03;
localparam int OPC_JALR  = 'h67;
localparam int OPC_LUI   = 'h37;
localparam int OPC_AUIPC = 'h17;

string       testNames [NUM_TESTS];
logic [31:0] testProg  [NUM_TESTS][MAX_PROG];
logic [31:0] testExp   [NUM_TESTS][MAX_STORES];   // Word stored at 0x100 + 4k
logic [31:0] testPc    [NUM_TESTS][MAX_STORES];   // Address of each store instruction
int          progLen   [NUM_TESTS];
int          numStores [NUM_TESTS];

function automatic logic [31:0] encR(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
endfunction

function automatic logic [31:0] encI(int imm, int rs1, int f3, int rd, int op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

// SW only with funct3 010
function automatic logic [31:0] encS(int imm, int rs2, int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] encB(int off, int rs2, int rs1, int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
endfunction

function automatic logic [31:0] encU(int imm20, int rd, int op);
    return {imm20[19:0], rd[4:0], op[6:0]};
endfunction

function automatic logic [31:0] encJ(int off, int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
endfunction

task automatic emit(input int row, input logic [31:0] inst);
    testProg[row][progLen[row]] = inst;
    progLen[row]++;
endtask

// Store register rs2 to the k-th result slot and record what should land there
task automatic storeReg(input int row, input int rs2, input logic [31:0] value);
    testPc[row][numStores[row]] = 32'(4 * progLen[row]);
    emit(row, encS(256 + 4 * numStores[row], rs2, 0));
    testExp[row][numStores[row]] = value;
    numStores[row]++;
endtask

task automatic buildTable();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] s;
    logic [31:0] sa;
    logic [31:0] sb;
    foreach (progLen[r]) begin
        progLen[r]   = 0;
        numStores[r] = 0;
    end
    testNames[0] = "arith";                        // Signed and unsigned mixes
    emit(0, encI(-5, 0, 0, 1, OPC_IMM));
    emit(0, encI(3, 0, 0, 2, OPC_IMM));
    emit(0, encR(32, 2, 1, 0, 3));                 // sub
    emit(0, encR(0, 2, 1, 2, 4));                  // slt  -5 < 3
    emit(0, encR(0, 2, 1, 3, 5));                  // sltu huge < 3
    emit(0, encR(0, 1, 2, 3, 6));                  // sltu 3 < huge
    emit(0, encI('h401, 1, 5, 7, OPC_IMM));        // srai by 1
    storeReg(0, 3, 32'hFFFF_FFF8);
    storeReg(0, 4, 32'd1);
    storeReg(0, 5, 32'd0);
    storeReg(0, 6, 32'd1);
    storeReg(0, 7, 32'hFFFF_FFFD);
    testNames[1] = "lfsr";
    drawBits(12, a);
    drawBits(12, b);
    drawBits(12, s);                               // Bits above 4 must be ignored
    sa = {{20{a[11]}}, a[11:0]};
    sb = {{20{b[11]}}, b[11:0]};
    emit(1, encI(a, 0, 0, 1, OPC_IMM));
    emit(1, encI(b, 0, 0, 2, OPC_IMM));
    emit(1, encI(s, 0, 0, 3, OPC_IMM));
    emit(1, encR(0, 2, 1, 0, 4));
    emit(1, encR(0, 2, 1, 4, 5));
    emit(1, encR(0, 2, 1, 6, 6));
    emit(1, encR(0, 2, 1, 7, 7));
    emit(1, encR(0, 3, 1, 1, 8));
    emit(1, encR(0, 3, 1, 5, 9));
    emit(1, encR(32, 3, 1, 5, 10));
    storeReg(1, 4, sa + sb);
    storeReg(1, 5, sa ^ sb);
    storeReg(1, 6, sa | sb);
    storeReg(1, 7, sa & sb);
    storeReg(1, 8, sa << s[4:0]);
    storeReg(1, 9, sa >> s[4:0]);
    storeReg(1, 10, 32'($signed(sa) >>> s[4:0]));
    testNames[2] = "upper";
    emit(2, encU('h12345, 1, OPC_LUI));
    emit(2, encU('h00001, 2, OPC_AUIPC));          // Sits at address 4
    storeReg(2, 1, 32'h1234_5000);
    storeReg(2, 2, 32'h0000_1004);
    testNames[3] = "load";
    emit(3, encI('h5A5, 0, 0, 1, OPC_IMM));
    storeReg(3, 1, 32'h0000_05A5);
    emit(3, encI('h100, 0, 2, 2, OPC_LOAD));       // lw x2, 0x100(x0)
    emit(3, encI(7, 0, 0, 0, OPC_IMM));            // Write to x0
    storeReg(3, 2, 32'h0000_05A5);
    storeReg(3, 0, 32'd0);
    // Each branch jumps over one addi and x3 collects a bit per fall-through
    testNames[4] = "branchTaken";
    testNames[5] = "branchNotTaken";
    for (int r = 4; r <= 5; r++) begin
        emit(r, encI(-1, 0, 0, 1, OPC_IMM));
        emit(r, encI(1, 0, 0, 2, OPC_IMM));
    end
    emit(4, encB(8, 1, 1, 0));
    emit(4, encI(1, 3, 0, 3, OPC_IMM));
    emit(4, encB(8, 2, 1, 1));
    emit(4, encI(2, 3, 0, 3, OPC_IMM));
    emit(4, encB(8, 2, 1, 4));
    emit(4, encI(4, 3, 0, 3, OPC_IMM));
    emit(4, encB(8, 1, 2, 5));
    emit(4, encI(8, 3, 0, 3, OPC_IMM));
    emit(4, encB(8, 1, 2, 6));
    emit(4, encI(16, 3, 0, 3, OPC_IMM));
    emit(4, encB(8, 2, 1, 7));
    emit(4, encI(32, 3, 0, 3, OPC_IMM));
    emit(5, encB(8, 2, 1, 0));
    emit(5, encI(1, 3, 0, 3, OPC_IMM));
    emit(5, encB(8, 1, 1, 1));
    emit(5, encI(2, 3, 0, 3, OPC_IMM));
    emit(5, encB(8, 1, 2, 4));
    emit(5, encI(4, 3, 0, 3, OPC_IMM));
    emit(5, encB(8, 2, 1, 5));
    emit(5, encI(8, 3, 0, 3, OPC_IMM));
    emit(5, encB(8, 2, 1, 6));
    emit(5, encI(16, 3, 0, 3, OPC_IMM));
    emit(5, encB(8, 1, 2, 7));
    emit(5, encI(32, 3, 0, 3, OPC_IMM));
    storeReg(4, 3, 32'd0);
    storeReg(5, 3, 32'h0000_003F);
    testNames[6] = "jump";
    emit(6, encJ(8, 1));                           // jal at 0 to 8
    emit(6, encI(1, 0, 0, 5, OPC_IMM));            // Skipped at 4
    storeReg(6, 1, 32'd4);                         // Store at 8
    emit(6, encI(25, 0, 0, 2, OPC_IMM));           // Odd target at 12
    emit(6, encI(0, 2, 0, 3, OPC_JALR));           // jalr at 16 lands on 24
    emit(6, encI(2, 0, 0, 5, OPC_IMM));            // Skipped at 20
    storeReg(6, 3, 32'd20);
    storeReg(6, 5, 32'd0);
    testNames[7] = "reset";                        // Store is the first instruction
    storeReg(7, 0, 32'd0);
    emit(7, encI(77, 0, 0, 1, OPC_IMM));
    storeReg(7, 1, 32'd77);
endtask

`endif

// File: bench/processorTb.sv
module processorTb;

    localparam int PROG_DEPTH = 64;
    localparam int DATA_DEPTH = 256;
    localparam int STORE_TIMEOUT = 200;    // Cycles allowed per expected store

    logic        i_Clock;
    logic        i_rstN;
    logic [31:0] o_PgmAddr;
    logic [31:0] i_PgmInst;
    logic [31:0] o_MemAddr;
    logic        o_MemWrEnable;
    logic [31:0] o_MemWrData;
    logic [31:0] i_MemRdData;

    logic [31:0] progMem [PROG_DEPTH];
    logic [31:0] dataMem [DATA_DEPTH];

    logic [31:0] lfsrState = 32'd41;
    int          mismatchCount = 0;
    int          timeoutCount  = 0;
    int          resetErrCount = 0;

    processorSc #(
        .DATA_WIDTH (32),
        .PC_WIDTH   (32),
        .REG_WIDTH  (5)
    ) dut_i (
        .i_Clock       (i_Clock),
        .i_rstN        (i_rstN),
        .o_PgmAddr     (o_PgmAddr),
        .i_PgmInst     (i_PgmInst),
        .o_MemAddr     (o_MemAddr),
        .o_MemWrEnable (o_MemWrEnable),
        .o_MemWrData   (o_MemWrData),
        .i_MemRdData   (i_MemRdData)
    );

    always #20 i_Clock = ~i_Clock;

    // Word-addressed memories answering in the same cycle
    assign i_PgmInst   = progMem[o_PgmAddr[7:2]];
    assign i_MemRdData = dataMem[o_MemAddr[9:2]];

    always @(posedge i_Clock) begin
        if (o_MemWrEnable) begin
            dataMem[o_MemAddr[9:2]] <= o_MemWrData;
        end
    end

    // Galois LFSR with taps 32 30 26 25
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic drawBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v         = {v[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);   // One step per bit
        end
    endtask

    `include "testTable.svh"

    // Strobe must stay low for the whole reset
    always @(negedge i_Clock) begin
        if (!i_rstN && o_MemWrEnable === 1'b1) begin
            $display("store strobe high while reset is asserted");
            resetErrCount++;
        end
    end

    task automatic runTest(input int t);
        logic [31:0] expAddr;
        bit          found;
        @(posedge i_Clock);
        i_rstN <= 1'b0;
        @(negedge i_Clock);                            // Memories change while the core is held
        for (int i = 0; i < PROG_DEPTH; i++) begin
            progMem[i] = (i < progLen[t]) ? testProg[t][i] : 32'h0;   // Zero is a no-op
        end
        for (int i = 0; i < DATA_DEPTH; i++) begin
            dataMem[i] = {~i[7:0], 8'hDA, i[7:0], 8'h7A};   // Address-dependent fill
        end
        repeat (3) @(posedge i_Clock);
        i_rstN <= 1'b1;
        for (int k = 0; k < numStores[t]; k++) begin
            found = 1'b0;
            for (int cyc = 0; cyc < STORE_TIMEOUT && !found; cyc++) begin
                @(negedge i_Clock);                    // Mid-cycle once outputs have settled
                if (o_MemWrEnable) begin
                    found = 1'b1;
                end
            end
            if (!found) begin
                $display("store never happened in test %s, store %0d", testNames[t], k);
                timeoutCount++;
                return;
            end
            if (o_PgmAddr !== testPc[t][k]) begin
                $display("mismatch %s store %0d pc: expected %h, actual %h",
                         testNames[t], k, testPc[t][k], o_PgmAddr);
                mismatchCount++;
            end
            expAddr = 32'h100 + 32'(4 * k);
            if (o_MemAddr !== expAddr) begin
                $display("mismatch %s store %0d address: expected %h, actual %h",
                         testNames[t], k, expAddr, o_MemAddr);
                mismatchCount++;
            end
            if (o_MemWrData !== testExp[t][k]) begin
                $display("mismatch %s store %0d data: expected %h, actual %h",
                         testNames[t], k, testExp[t][k], o_MemWrData);
                mismatchCount++;
            end
        end
    endtask

    initial begin
        i_Clock = 1'b0;
        i_rstN  = 1'b0;
        for (int i = 0; i < PROG_DEPTH; i++) begin
            progMem[i] = 32'h0;
        end
        buildTable();
        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d reset violations",
                 mismatchCount, timeoutCount, resetErrCount);
        if (mismatchCount + timeoutCount + resetErrCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: processorSc.f
+incdir+bench
design/isaPkg.sv
design/coreCtrlPkg.sv
design/instructionDecoder.sv
design/datapathController.sv
design/registerFile.sv
design/alu.sv
design/processorSc.sv
bench/processorTb.sv

// File: Makefile
TOP := processorTb

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f processorSc.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
